//--- common/riscv_isa_pkg.sv
// RV32I encodings for the subset the core executes
package riscv_isa_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    localparam logic [xlen-1:0] pc_step = 32'd4;    // One instruction word

    // --------------------
    // Major opcodes
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;

    // --------------------
    // funct3 codes
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    localparam logic [2:0] f3_sb  = 3'b000;
    localparam logic [2:0] f3_sh  = 3'b001;
    localparam logic [2:0] f3_sw  = 3'b010;
    localparam logic [2:0] f3_beq = 3'b000;
    localparam logic [2:0] f3_bne = 3'b001;

    localparam logic [6:0] funct7_alt = 7'b0100000;    // SUB and SRA/SRAI

    localparam logic [xlen-1:0] nop_instr = 32'h0000_0013;    // ADDI x0,x0,0

    // Bit positions of the instruction fields
    localparam int rd_lsb     = 7;
    localparam int funct3_lsb = 12;
    localparam int rs1_lsb    = 15;
    localparam int rs2_lsb    = 20;
    localparam int funct7_lsb = 25;

endpackage

//--- common/core_pkg.sv
// Pipeline types of the core
package core_pkg;

    typedef logic [riscv_isa_pkg::xlen-1:0]       word_t;
    typedef logic [riscv_isa_pkg::reg_addr_w-1:0] reg_addr_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_t;

    typedef enum logic [1:0] {
        width_byte = 2'b00,
        width_half = 2'b01,
        width_word = 2'b10
    } mem_width_t;

    typedef enum logic [1:0] {
        br_none,
        br_eq,
        br_ne
    } branch_t;

    // --------------------
    // Stage boundaries
    typedef struct packed {
        word_t pc;
        word_t instr;
    } ifid_t;

    typedef struct packed {
        word_t      pc;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        reg_addr_t  rd;
        word_t      op1;            // Register values read in decode
        word_t      op2;
        word_t      imm;
        alu_op_t    alu_op;
        logic       alu_src_imm;
        logic       reg_write;
        logic       mem_write;
        mem_width_t mem_width;
        branch_t    branch;
    } idex_t;

    typedef struct packed {
        word_t      alu_result;
        word_t      store_data;
        reg_addr_t  rd;
        logic       reg_write;
        logic       mem_write;
        mem_width_t mem_width;
    } exmem_t;

    typedef struct packed {
        word_t     alu_result;
        reg_addr_t rd;
        logic      reg_write;
    } memwb_t;

    // External data request, write doubles as valid
    typedef struct packed {
        logic       write;
        mem_width_t width;
        word_t      addr;
        word_t      wdata;
    } dmem_req_t;

    // Result of a later stage offered to execute
    typedef struct packed {
        reg_addr_t rd;
        logic      reg_write;
        word_t     value;
    } fwd_t;

    // --------------------
    // Bubbles
    localparam ifid_t ifid_bubble = '{pc: '0, instr: riscv_isa_pkg::nop_instr};

    localparam idex_t idex_bubble = '{
        alu_op:    alu_add,
        mem_width: width_word,
        branch:    br_none,
        default:   '0
    };

    localparam exmem_t exmem_bubble = '{mem_width: width_word, default: '0};
    localparam memwb_t memwb_bubble = '{default: '0};

endpackage

//--- core/pipe_reg.sv
// Stage boundary, hold wins over squash
module pipe_reg #(
    parameter type      payload_t = logic,
    parameter payload_t bubble    = '0
) (
    input  logic     clk,
    input  logic     reset_n,
    input  logic     hold,
    input  logic     squash,
    input  payload_t d,
    output payload_t q
);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            q <= bubble;
        end else if (!hold) begin
            q <= squash ? bubble : d;
        end
    end

endmodule

//--- core/fetch_stage.sv
module fetch_stage (
    input  logic            clk,
    input  logic            reset_n,
    input  logic            hold,
    input  logic            imem_ready,
    input  core_pkg::word_t imem_rdata,
    input  logic            redirect,
    input  core_pkg::word_t redirect_pc,
    output core_pkg::word_t imem_addr,
    output core_pkg::ifid_t ifid
);
    import riscv_isa_pkg::*;
    import core_pkg::*;

    word_t pc;
    ifid_t fetched;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pc <= '0;
        end else if (!hold) begin
            if (redirect) begin
                pc <= redirect_pc;      // Taken branch from EX/MEM
            end else if (imem_ready) begin
                pc <= pc + pc_step;
            end
        end
    end

    assign imem_addr = pc;

    // No word this cycle means a NOP goes down the pipe
    assign fetched = imem_ready ? '{pc: pc, instr: imem_rdata} : ifid_bubble;

    pipe_reg #(
        .payload_t (ifid_t),
        .bubble    (ifid_bubble)
    ) u_ifid (
        .clk     (clk),
        .reset_n (reset_n),
        .hold    (hold),
        .squash  (redirect),
        .d       (fetched),
        .q       (ifid)
    );

endmodule

//--- core/decode_stage.sv
module decode_stage (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                hold,
    input  logic                squash,
    input  core_pkg::ifid_t     ifid,
    output core_pkg::reg_addr_t rs1_addr,
    output core_pkg::reg_addr_t rs2_addr,
    input  core_pkg::word_t     rs1_val,
    input  core_pkg::word_t     rs2_val,
    output core_pkg::idex_t     idex
);
    import riscv_isa_pkg::*;
    import core_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       alt;            // funct7 marks SUB or SRA
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_shamt;
    logic       known;
    idex_t      dec;
    idex_t      idex_d;

    assign opcode   = ifid.instr[6:0];
    assign funct3   = ifid.instr[funct3_lsb +: 3];
    assign alt      = (ifid.instr[funct7_lsb +: 7] == funct7_alt);
    assign rs1_addr = ifid.instr[rs1_lsb +: reg_addr_w];
    assign rs2_addr = ifid.instr[rs2_lsb +: reg_addr_w];

    // --------------------
    // Immediates
    assign imm_i     = {{20{ifid.instr[31]}}, ifid.instr[31:20]};
    assign imm_s     = {{20{ifid.instr[31]}}, ifid.instr[31:25], ifid.instr[11:7]};
    assign imm_b     = {{20{ifid.instr[31]}}, ifid.instr[7], ifid.instr[30:25],
                        ifid.instr[11:8], 1'b0};
    assign imm_shamt = word_t'(ifid.instr[rs2_lsb +: reg_addr_w]);

    // --------------------
    // Control decode
    always_comb begin
        dec     = idex_bubble;
        dec.pc  = ifid.pc;
        dec.rs1 = rs1_addr;
        dec.rs2 = rs2_addr;
        dec.rd  = ifid.instr[rd_lsb +: reg_addr_w];
        dec.op1 = rs1_val;
        dec.op2 = rs2_val;
        dec.imm = imm_i;
        known   = 1'b1;

        case (opcode)
            op_reg, op_imm: begin
                dec.reg_write   = 1'b1;
                dec.alu_src_imm = (opcode == op_imm);
                case (funct3)
                    f3_add_sub: dec.alu_op = (alt && opcode == op_reg) ? alu_sub : alu_add;
                    f3_sll:     dec.alu_op = alu_sll;
                    f3_slt:     dec.alu_op = alu_slt;
                    f3_sltu:    dec.alu_op = alu_sltu;
                    f3_xor:     dec.alu_op = alu_xor;
                    f3_srl_sra: dec.alu_op = alt ? alu_sra : alu_srl;
                    f3_or:      dec.alu_op = alu_or;
                    default:    dec.alu_op = alu_and;
                endcase
                // SLLI, SRLI, SRAI
                if (opcode == op_imm && (funct3 == f3_sll || funct3 == f3_srl_sra)) begin
                    dec.imm = imm_shamt;
                end
            end
            op_store: begin
                dec.mem_write   = 1'b1;
                dec.alu_src_imm = 1'b1;         // Address is rs1 + offset
                dec.imm         = imm_s;
                case (funct3)
                    f3_sb:   dec.mem_width = width_byte;
                    f3_sh:   dec.mem_width = width_half;
                    f3_sw:   dec.mem_width = width_word;
                    default: known = 1'b0;
                endcase
            end
            op_branch: begin
                dec.alu_op = alu_sub;           // Compare on the difference
                dec.imm    = imm_b;
                case (funct3)
                    f3_beq:  dec.branch = br_eq;
                    f3_bne:  dec.branch = br_ne;
                    default: known = 1'b0;
                endcase
            end
            default: known = 1'b0;
        endcase
    end

    assign idex_d = known ? dec : idex_bubble;

    pipe_reg #(
        .payload_t (idex_t),
        .bubble    (idex_bubble)
    ) u_idex (
        .clk     (clk),
        .reset_n (reset_n),
        .hold    (hold),
        .squash  (squash),
        .d       (idex_d),
        .q       (idex)
    );

endmodule

//--- core/register_file.sv
module register_file (
    input  logic                clk,
    input  core_pkg::reg_addr_t rs1_addr,
    input  core_pkg::reg_addr_t rs2_addr,
    output core_pkg::word_t     rs1_val,
    output core_pkg::word_t     rs2_val,
    input  logic                wr_en,
    input  core_pkg::reg_addr_t wr_addr,
    input  core_pkg::word_t     wr_data
);
    import core_pkg::*;

    word_t regs [1:31];         // x0 has no storage

    // Write-through so decode sees the value retiring this cycle
    function automatic word_t read_port(input reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (wr_en && wr_addr == addr) begin
            return wr_data;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rs1_val = read_port(rs1_addr);
        rs2_val = read_port(rs2_addr);
    end

    always_ff @(posedge clk) begin
        if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

endmodule

//--- core/execute_stage.sv
module execute_stage (
    input  logic             clk,
    input  logic             reset_n,
    input  logic             hold,
    input  core_pkg::idex_t  idex,
    input  core_pkg::fwd_t   wb_fwd,
    output core_pkg::exmem_t exmem,
    output logic             redirect,
    output core_pkg::word_t  redirect_pc
);
    import core_pkg::*;

    fwd_t   mem_fwd;
    word_t  op_a;
    word_t  rs2_fwd;            // Also the store data
    word_t  op_b;
    word_t  alu_result;
    logic   taken;
    exmem_t exmem_d;

    // Youngest producer wins, x0 never forwarded
    function automatic word_t forward(
        input reg_addr_t rs,
        input word_t     decoded,
        input fwd_t      near,
        input fwd_t      far
    );
        if (rs != '0 && near.reg_write && near.rd == rs) begin
            return near.value;
        end
        if (rs != '0 && far.reg_write && far.rd == rs) begin
            return far.value;
        end
        return decoded;
    endfunction

    // --------------------
    // Operand select
    assign mem_fwd = '{rd: exmem.rd, reg_write: exmem.reg_write, value: exmem.alu_result};
    assign op_a    = forward(idex.rs1, idex.op1, mem_fwd, wb_fwd);
    assign rs2_fwd = forward(idex.rs2, idex.op2, mem_fwd, wb_fwd);
    assign op_b    = idex.alu_src_imm ? idex.imm : rs2_fwd;

    // --------------------
    // ALU
    always_comb begin
        case (idex.alu_op)
            alu_sub:  alu_result = op_a - op_b;
            alu_sll:  alu_result = op_a << op_b[4:0];
            alu_slt:  alu_result = word_t'($signed(op_a) < $signed(op_b));
            alu_sltu: alu_result = word_t'(op_a < op_b);
            alu_xor:  alu_result = op_a ^ op_b;
            alu_srl:  alu_result = op_a >> op_b[4:0];
            alu_sra:  alu_result = word_t'($signed(op_a) >>> op_b[4:0]);
            alu_or:   alu_result = op_a | op_b;
            alu_and:  alu_result = op_a & op_b;
            default:  alu_result = op_a + op_b;
        endcase
    end

    always_comb begin
        case (idex.branch)
            br_eq:   taken = (alu_result == '0);
            br_ne:   taken = (alu_result != '0);
            default: taken = 1'b0;
        endcase
    end

    // Redirect lives beside EX/MEM and kills the three younger slots
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            redirect <= 1'b0;
        end else if (!hold) begin
            redirect <= taken && !redirect;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            redirect_pc <= idex.pc + idex.imm;
        end
    end

    assign exmem_d = '{
        alu_result: alu_result,
        store_data: rs2_fwd,
        rd:         idex.rd,
        reg_write:  idex.reg_write,
        mem_write:  idex.mem_write,
        mem_width:  idex.mem_width
    };

    pipe_reg #(
        .payload_t (exmem_t),
        .bubble    (exmem_bubble)
    ) u_exmem (
        .clk     (clk),
        .reset_n (reset_n),
        .hold    (hold),
        .squash  (redirect),
        .d       (exmem_d),
        .q       (exmem)
    );

endmodule

//--- core/memory_stage.sv
module memory_stage (
    input  logic                clk,
    input  logic                reset_n,
    input  core_pkg::exmem_t    exmem,
    input  logic                dmem_ready,
    output core_pkg::dmem_req_t dmem_req,
    output logic                hold,
    output logic                wr_en,
    output core_pkg::reg_addr_t wr_addr,
    output core_pkg::word_t     wr_data,
    output core_pkg::fwd_t      wb_fwd
);
    import core_pkg::*;

    memwb_t memwb_d;
    memwb_t memwb;

    assign hold = !dmem_ready;  // Freezes everything up to EX/MEM

    // Request straight from EX/MEM, stable while held
    assign dmem_req = '{
        write: exmem.mem_write,
        width: exmem.mem_width,
        addr:  exmem.alu_result,
        wdata: exmem.store_data
    };

    assign memwb_d = '{alu_result: exmem.alu_result, rd: exmem.rd, reg_write: exmem.reg_write};

    pipe_reg #(
        .payload_t (memwb_t),
        .bubble    (memwb_bubble)
    ) u_memwb (
        .clk     (clk),
        .reset_n (reset_n),
        .hold    (1'b0),
        .squash  (hold),        // Bubble while the port stalls
        .d       (memwb_d),
        .q       (memwb)
    );

    // --------------------
    // Writeback
    assign wr_en   = memwb.reg_write;
    assign wr_addr = memwb.rd;
    assign wr_data = memwb.alu_result;

    // Tracks MEM/WB but keeps its entry over a stall, since the held
    // ID/EX operands were read before that result reached the registers
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wb_fwd <= '0;
        end else if (!hold) begin
            wb_fwd <= '{rd: exmem.rd, reg_write: exmem.reg_write, value: exmem.alu_result};
        end
    end

endmodule

//--- hdl/cpu.sv
module cpu (
    input  logic                clk,
    input  logic                reset_n,
    output core_pkg::word_t     imem_addr,
    input  core_pkg::word_t     imem_rdata,
    input  logic                imem_ready,
    output core_pkg::dmem_req_t dmem_req,
    input  logic                dmem_ready
);
    import core_pkg::*;

    logic      hold;            // Data port back-pressure
    ifid_t     ifid;
    idex_t     idex;
    exmem_t    exmem;
    logic      redirect;
    word_t     redirect_pc;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_val;
    word_t     rs2_val;
    logic      wr_en;
    reg_addr_t wr_addr;
    word_t     wr_data;
    fwd_t      wb_fwd;

    fetch_stage u_fetch (
        .clk         (clk),
        .reset_n     (reset_n),
        .hold        (hold),
        .imem_ready  (imem_ready),
        .imem_rdata  (imem_rdata),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .imem_addr   (imem_addr),
        .ifid        (ifid)
    );

    decode_stage u_decode (
        .clk      (clk),
        .reset_n  (reset_n),
        .hold     (hold),
        .squash   (redirect),
        .ifid     (ifid),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_val  (rs1_val),
        .rs2_val  (rs2_val),
        .idex     (idex)
    );

    register_file u_regfile (
        .clk      (clk),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_val  (rs1_val),
        .rs2_val  (rs2_val),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data)
    );

    execute_stage u_execute (
        .clk         (clk),
        .reset_n     (reset_n),
        .hold        (hold),
        .idex        (idex),
        .wb_fwd      (wb_fwd),
        .exmem       (exmem),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    memory_stage u_memory (
        .clk        (clk),
        .reset_n    (reset_n),
        .exmem      (exmem),
        .dmem_ready (dmem_ready),
        .dmem_req   (dmem_req),
        .hold       (hold),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .wb_fwd     (wb_fwd)
    );

endmodule

//--- testbench/cpu_properties.sv
module cpu_properties (
    input logic                clk,
    input logic                reset_n,
    input core_pkg::word_t     imem_addr,
    input core_pkg::dmem_req_t dmem_req,
    input logic                dmem_ready
);
    timeunit 1ns;
    timeprecision 100ps;

    // EX/MEM is cleared by reset
    no_write_in_reset: assert property (
        @(posedge clk) !reset_n |-> !dmem_req.write
    ) else $error("store request raised while reset is active");

    pc_word_aligned: assert property (
        @(posedge clk) disable iff (!reset_n) imem_addr[1:0] == 2'b00
    ) else $error("instruction address not word aligned");

    // --------------------
    // Back-pressure on the data port
    req_stable_while_waiting: assert property (
        @(posedge clk) disable iff (!reset_n)
        dmem_req.write && !dmem_ready |=> $stable(dmem_req)
    ) else $error("store request changed before it was accepted");

    pc_frozen_while_waiting: assert property (
        @(posedge clk) disable iff (!reset_n)
        !dmem_ready |=> $stable(imem_addr)
    ) else $error("fetch address moved while the data port stalled");

endmodule

bind cpu cpu_properties u_properties (
    .clk        (clk),
    .reset_n    (reset_n),
    .imem_addr  (imem_addr),
    .dmem_req   (dmem_req),
    .dmem_ready (dmem_ready)
);

//--- testbench/cpu_tb.sv
module cpu_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import riscv_isa_pkg::*;
    import core_pkg::*;

    localparam int imem_words   = 64;
    localparam int stall_factor = 12;       // Cycles allowed per instruction
    localparam int run_margin   = 40;       // Reset, halt loop and drain
    localparam int drain_cycles = 8;

    logic      clk = 1'b0;
    logic      reset_n;
    word_t     imem_addr;
    word_t     imem_rdata;
    logic      imem_ready;
    dmem_req_t dmem_req;
    logic      dmem_ready;

    word_t     imem [0:imem_words-1];
    word_t     prog [$];
    dmem_req_t expected [$];
    int        store_idx;
    logic      capture;
    logic      stall_mode;
    string     test_name;
    int        checks;
    int        errors;
    int        budget_cycles = 16;      // Covers the reset test
    int        cycle_count;

    cpu uut (
        .clk        (clk),
        .reset_n    (reset_n),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .imem_ready (imem_ready),
        .dmem_req   (dmem_req),
        .dmem_ready (dmem_ready)
    );

    // Instruction memory with NOP beyond its 64 words
    assign imem_rdata = (imem_addr < imem_words * 4) ? imem[imem_addr[7:2]] : nop_instr;

    initial begin
        forever #4 clk = ~clk;
    end

    // --------------------
    // Port ready driver
    initial begin : ready_driver
        int unsigned seed_ack;
        seed_ack   = $urandom(3346);
        imem_ready = 1'b1;
        dmem_ready = 1'b1;
        forever begin
            @(negedge clk);
            if (stall_mode) begin
                imem_ready = ($urandom % 4) != 0;
                dmem_ready = ($urandom % 3) != 0;
            end else begin
                imem_ready = 1'b1;
                dmem_ready = 1'b1;
            end
        end
    end

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count <= budget_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Watchdog expired after %0d cycles, %s never reached its halt loop",
                 cycle_count, test_name);
        $display("Simulation failed");
        $finish;
    end

    // Store completes where write and ready meet at the edge
    always @(posedge clk) begin
        if (capture && reset_n && dmem_req.write && dmem_ready) begin
            check_store(dmem_req);
            store_idx++;
        end
    end

    // --------------------
    // Instruction encoders
    function automatic word_t r_type(input logic [6:0] f7, input logic [2:0] f3,
                                     input reg_addr_t rd, input reg_addr_t rs1,
                                     input reg_addr_t rs2);
        return {f7, rs2, rs1, f3, rd, op_reg};
    endfunction

    function automatic word_t i_type(input logic [2:0] f3, input reg_addr_t rd,
                                     input reg_addr_t rs1, input word_t imm);
        return {imm[11:0], rs1, f3, rd, op_imm};
    endfunction

    function automatic word_t s_type(input logic [2:0] f3, input reg_addr_t rs2,
                                     input word_t off, input reg_addr_t rs1);
        return {off[11:5], rs2, rs1, f3, off[4:0], op_store};
    endfunction

    function automatic word_t b_type(input logic [2:0] f3, input reg_addr_t rs1,
                                     input reg_addr_t rs2, input word_t off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_branch};
    endfunction

    // --------------------
    // Program and check helpers
    task automatic start_program(input string name);
        test_name = name;
        prog.delete();
        expected.delete();
    endtask

    task automatic append_instr(input word_t instr);
        prog.push_back(instr);
    endtask

    task automatic expect_store(input mem_width_t width, input word_t addr, input word_t data);
        expected.push_back(dmem_req_t'{write: 1'b1, width: width, addr: addr, wdata: data});
    endtask

    task automatic expect_value(input string what, input word_t exp, input word_t obs);
        checks++;
        assert (obs === exp) else begin
            errors++;
            $display("** Error at %0t: %s expected %h observed %h", $time, what, exp, obs);
        end
    endtask

    task automatic check_store(input dmem_req_t obs);
        dmem_req_t exp;
        checks++;
        assert (store_idx < expected.size()) else begin
            errors++;
            $display("** Error at %0t: %s extra store width %0d addr %h data %h",
                     $time, test_name, obs.width, obs.addr, obs.wdata);
        end
        if (store_idx < expected.size()) begin
            exp = expected[store_idx];
            assert (obs == exp) else begin
                errors++;
                $display("** Error at %0t: %s store %0d expected %0d/%h/%h observed %0d/%h/%h",
                         $time, test_name, store_idx, exp.width, exp.addr, exp.wdata,
                         obs.width, obs.addr, obs.wdata);
            end
        end
    endtask

    // Loads under reset, then waits for the closing self-branch to loop
    task automatic run_until_halt();
        word_t halt_pc;
        word_t prev_addr;
        logic  looped;
        append_instr(b_type(f3_beq, 0, 0, 0));
        @(negedge clk);
        reset_n = 1'b0;
        for (int i = 0; i < imem_words; i++) begin
            imem[i] = (i < prog.size()) ? prog[i] : nop_instr;
        end
        halt_pc        = word_t'(prog.size() - 1) * pc_step;
        budget_cycles += prog.size() * stall_factor + run_margin;
        store_idx      = 0;
        capture        = 1'b1;
        repeat (3) @(negedge clk);
        reset_n   = 1'b1;
        prev_addr = '0;
        looped    = 1'b0;
        // Only the halt branch jumps back to itself from past the program end
        while (!looped) begin
            @(negedge clk);
            looped    = (prev_addr > halt_pc) && (imem_addr == halt_pc);
            prev_addr = imem_addr;
        end
        repeat (drain_cycles) @(negedge clk);
        capture = 1'b0;
        checks++;
        assert (store_idx == expected.size()) else begin
            errors++;
            $display("** Error at %0t: %s expected %0d stores observed %0d",
                     $time, test_name, expected.size(), store_idx);
        end
    endtask

    // --------------------
    // Directed tests
    task automatic test_reset();
        test_name = "reset";
        repeat (3) begin
            @(negedge clk);
            expect_value("imem_addr in reset", '0, imem_addr);
            expect_value("dmem_req.write in reset", '0, dmem_req.write);
        end
        reset_n = 1'b1;
        expect_value("imem_addr after reset", '0, imem_addr);
        @(negedge clk);
        expect_value("imem_addr after first fetch", pc_step, imem_addr);
        expect_value("dmem_req.write after reset", '0, dmem_req.write);
    endtask

    task automatic build_register_program();
        word_t x [0:13];
        x[1] = -100;
        x[2] = 5;
        append_instr(i_type(f3_add_sub, 3, 0, 'h100));
        append_instr(i_type(f3_add_sub, 1, 0, x[1]));
        append_instr(i_type(f3_add_sub, 2, 0, x[2]));
        // Back to back so nearly every operand is forwarded
        x[4] = x[1] + x[2];
        append_instr(r_type(7'd0, f3_add_sub, 4, 1, 2));
        x[5] = x[4] - x[2];
        append_instr(r_type(funct7_alt, f3_add_sub, 5, 4, 2));
        x[6] = x[5] << x[2][4:0];
        append_instr(r_type(7'd0, f3_sll, 6, 5, 2));
        x[7] = word_t'($signed(x[6]) < $signed(x[5]));
        append_instr(r_type(7'd0, f3_slt, 7, 6, 5));
        x[8] = word_t'(x[5] < x[7]);
        append_instr(r_type(7'd0, f3_sltu, 8, 5, 7));
        x[9] = x[6] ^ x[1];
        append_instr(r_type(7'd0, f3_xor, 9, 6, 1));
        x[10] = x[9] >> x[2][4:0];
        append_instr(r_type(7'd0, f3_srl_sra, 10, 9, 2));
        x[11] = $signed(x[6]) >>> x[2][4:0];
        append_instr(r_type(funct7_alt, f3_srl_sra, 11, 6, 2));
        x[12] = x[11] | x[10];
        append_instr(r_type(7'd0, f3_or, 12, 11, 10));
        x[13] = x[12] & x[9];
        append_instr(r_type(7'd0, f3_and, 13, 12, 9));
        for (int r = 4; r <= 13; r++) begin
            append_instr(s_type(f3_sw, r, (r - 4) * 4, 3));
            expect_store(width_word, 'h100 + (r - 4) * 4, x[r]);
        end
    endtask

    task automatic test_register_ops();
        start_program("register ops");
        build_register_program();
        run_until_halt();
    endtask

    task automatic test_immediate_ops();
        word_t x [0:10];
        start_program("immediate ops");
        append_instr(i_type(f3_add_sub, 11, 0, 'h200));
        x[1] = -1000;
        append_instr(i_type(f3_add_sub, 1, 0, -1000));
        x[2] = x[1] - 24;
        append_instr(i_type(f3_add_sub, 2, 1, -24));
        x[3] = x[2] ^ 32'hFFFF_FFFF;
        append_instr(i_type(f3_xor, 3, 2, -1));
        x[4] = x[3] | 32'hFFFF_F800;
        append_instr(i_type(f3_or, 4, 3, -2048));
        x[5] = x[4] & 32'hFFFF_FFF0;
        append_instr(i_type(f3_and, 5, 4, -16));
        x[6] = word_t'($signed(x[2]) < -1023);
        append_instr(i_type(f3_slt, 6, 2, -1023));
        x[7] = word_t'(x[1] < 32'hFFFF_FFFF);
        append_instr(i_type(f3_sltu, 7, 1, -1));
        x[8] = x[2] << 4;
        append_instr(i_type(f3_sll, 8, 2, 4));
        x[9] = x[2] >> 4;
        append_instr(i_type(f3_srl_sra, 9, 2, 4));
        x[10] = $signed(x[2]) >>> 4;
        append_instr(i_type(f3_srl_sra, 10, 2, 'h404));     // SRAI marker in imm[11:5]
        for (int r = 1; r <= 10; r++) begin
            append_instr(s_type(f3_sw, r, (r - 1) * 4, 11));
            expect_store(width_word, 'h200 + (r - 1) * 4, x[r]);
        end
        run_until_halt();
    endtask

    task automatic test_store_widths();
        word_t neg;
        word_t big;
        start_program("store widths");
        neg = -85;
        big = neg + 'h7ff;
        append_instr(i_type(f3_add_sub, 1, 0, 'h300));
        append_instr(i_type(f3_add_sub, 2, 0, neg));
        append_instr(s_type(f3_sb, 2, 5, 1));
        expect_store(width_byte, 'h305, neg);
        append_instr(s_type(f3_sh, 2, -6, 1));
        expect_store(width_half, 'h2fa, neg);
        append_instr(s_type(f3_sw, 2, -8, 1));
        expect_store(width_word, 'h2f8, neg);
        // Store data straight from EX/MEM
        append_instr(i_type(f3_add_sub, 3, 2, 'h7ff));
        append_instr(s_type(f3_sb, 3, -1, 1));
        expect_store(width_byte, 'h2ff, big);
        append_instr(s_type(f3_sh, 3, 2046, 1));
        expect_store(width_half, 'h300 + 2046, big);
        append_instr(s_type(f3_sw, 3, -2048, 1));
        expect_store(width_word, 'h300 - 2048, big);
        append_instr(i_type(f3_add_sub, 4, 0, 77));         // Reaches the store from MEM/WB
        append_instr(nop_instr);
        append_instr(s_type(f3_sw, 4, 12, 1));
        expect_store(width_word, 'h30c, 77);
        append_instr(i_type(f3_add_sub, 5, 0, -300));       // Through the register file
        append_instr(nop_instr);
        append_instr(nop_instr);
        append_instr(s_type(f3_sh, 5, -12, 1));
        expect_store(width_half, 'h2f4, -300);
        append_instr(i_type(f3_add_sub, 6, 1, 64));         // Forwarded address base
        append_instr(s_type(f3_sb, 2, 0, 6));
        expect_store(width_byte, 'h340, neg);
        run_until_halt();
    endtask

    task automatic test_branches();
        start_program("branches");
        append_instr(i_type(f3_add_sub, 1, 0, 'h400));
        append_instr(i_type(f3_add_sub, 2, 0, 9));
        append_instr(i_type(f3_add_sub, 3, 0, 9));
        append_instr(i_type(f3_add_sub, 4, 0, 3));
        append_instr(b_type(f3_beq, 2, 3, 16));             // Taken as 9 == 9
        for (int s = 0; s < 3; s++) begin
            append_instr(s_type(f3_sw, 4, 'h100 + s * 4, 1));
        end
        append_instr(s_type(f3_sw, 2, 0, 1));
        expect_store(width_word, 'h400, 9);
        append_instr(b_type(f3_bne, 2, 3, 8));              // Falls through
        append_instr(s_type(f3_sw, 3, 4, 1));
        expect_store(width_word, 'h404, 9);
        append_instr(s_type(f3_sw, 4, 8, 1));
        expect_store(width_word, 'h408, 3);
        append_instr(b_type(f3_bne, 2, 4, 16));             // Taken as 9 != 3
        for (int s = 0; s < 3; s++) begin
            append_instr(s_type(f3_sw, 2, 'h110 + s * 4, 1));
        end
        append_instr(s_type(f3_sw, 4, 12, 1));
        expect_store(width_word, 'h40c, 3);
        append_instr(b_type(f3_beq, 2, 4, 8));              // Falls through
        append_instr(s_type(f3_sw, 2, 16, 1));
        expect_store(width_word, 'h410, 9);
        append_instr(s_type(f3_sw, 3, 20, 1));
        expect_store(width_word, 'h414, 9);
        // Countdown loop with the backward branch taken twice
        append_instr(i_type(f3_add_sub, 5, 0, 3));
        append_instr(i_type(f3_add_sub, 5, 5, -1));
        append_instr(s_type(f3_sw, 5, 24, 1));
        append_instr(b_type(f3_bne, 5, 0, -8));
        for (int n = 2; n >= 0; n--) begin
            expect_store(width_word, 'h418, n);
        end
        append_instr(s_type(f3_sw, 4, 28, 1));               // Squashed until the loop exits
        expect_store(width_word, 'h41c, 3);
        run_until_halt();
    endtask

    task automatic test_back_pressure();
        start_program("back-pressure");
        build_register_program();
        stall_mode = 1'b1;
        run_until_halt();
        stall_mode = 1'b0;
    endtask

    // --------------------
    initial begin
        reset_n    = 1'b0;
        stall_mode = 1'b0;
        capture    = 1'b0;
        checks     = 0;
        errors     = 0;
        store_idx  = 0;
        test_name  = "";
        for (int i = 0; i < imem_words; i++) begin
            imem[i] = nop_instr;
        end

        test_reset();
        test_register_ops();
        test_immediate_ops();
        test_store_widths();
        test_branches();
        test_back_pressure();

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- cpu.f
common/riscv_isa_pkg.sv
common/core_pkg.sv
core/pipe_reg.sv
core/fetch_stage.sv
core/decode_stage.sv
core/register_file.sv
core/execute_stage.sv
core/memory_stage.sv
hdl/cpu.sv
testbench/cpu_properties.sv
testbench/cpu_tb.sv
